// ==== obj_engine_top.f ====
src/obj_video_pkg.sv
src/obj_attr_pkg.sv
src/obj_attr_ram.sv
src/obj_scan.sv
src/obj_line_buffer.sv
src/obj_engine_top.sv
verif/obj_engine_assert.sv
verif/obj_engine_tb.sv

// ==== Bender.yml ====
package:
  name: obj_engine

sources:
  - src/obj_video_pkg.sv
  - src/obj_attr_pkg.sv
  - src/obj_attr_ram.sv
  - src/obj_scan.sv
  - src/obj_line_buffer.sv
  - src/obj_engine_top.sv
  - target: test
    files:
      - verif/obj_engine_assert.sv
      - verif/obj_engine_tb.sv

// ==== verif/obj_engine_tb.sv ====
/*
 * Testbench for the sprite line engine. Loads the attribute table over
 * AXI4-Lite, models the graphics ROM with random ok delays and checks
 * every line read out against a reference built from the sprite rules.
 */
`timescale 1ns/100ps

module obj_engine_tb;
    import obj_video_pkg::*;
    import obj_attr_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int LINE_CYCLES = 1200;   // scan plus readout, upper bound
    localparam int MAX_LINES   = 40;
    localparam int WATCHDOG_NS = MAX_LINES * LINE_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        line_start;
    vpos_t       vrender;
    hpos_t       hdump;
    logic        pxl_cen;
    pixel_t      pxl;
    logic        done;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    logic        rom_ok;
    rom_data_t   rom_data;

    obj_word_t   attr [64];          // testbench copy of the table
    pixel_t      exp_next [LINE_W];  // line being rendered now
    pixel_t      exp_cur [LINE_W];   // line in the front bank
    int          cur_line;
    int          next_line;
    logic [31:0] lfsr;
    int          pxl_errors;
    int          axi_errors;
    int          other_errors;
    int          lines_run;

    obj_engine_top #(
        .OBJ_COUNT (64)
    ) i_obj_engine_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic logic lfsr_bit();
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        return lfsr[0];
    endfunction

    // graphics ROM contents
    function automatic logic [15:0] rom_word(input logic [15:0] a);
        return a * 16'h9e37;
    endfunction

    function automatic logic [31:0] make_obj(input logic [7:0] y, input logic [7:0] x,
                                             input logic [9:0] code, input logic [3:0] pal,
                                             input logic hflip, input logic big);
        return {y, x, code, pal, hflip, big};
    endfunction

    task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) begin
            next_cycle();
        end
        next_cycle();                 // taken at this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                attr[addr[7:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        repeat (2) next_cycle();      // response waits on bready
        while (!bvalid) begin
            next_cycle();
        end
        assert (bresp === 2'b00) else begin
            axi_errors++;
            $display("FAILED bresp: got %h, expected %h", bresp, 2'b00);
        end
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [7:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            next_cycle();
        end
        next_cycle();
        arvalid = 1'b0;
        repeat (2) next_cycle();      // rvalid must hold meanwhile
        while (!rvalid) begin
            next_cycle();
        end
        assert (rdata === attr[addr[7:2]]) else begin
            axi_errors++;
            $display("FAILED rdata at %h: got %h, expected %h", addr, rdata, attr[addr[7:2]]);
        end
        assert (rresp === 2'b00) else begin
            axi_errors++;
            $display("FAILED rresp: got %h, expected %h", rresp, 2'b00);
        end
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    // expected pixels of one line, lower index drawn first
    task automatic render_line(input logic [7:0] line);
        logic [31:0] w;
        logic [7:0]  row;
        logic [15:0] data;
        logic [3:0]  col;
        int          n_words;
        int          qi;
        int          pos;
        for (int i = 0; i < LINE_W; i++) begin
            exp_next[i] = '0;
        end
        for (int s = 0; s < 64; s++) begin
            w       = attr[s];
            row     = line - w[31:24];    // wraps mod 256
            n_words = w[0] ? 4 : 2;
            if (row < 4 * n_words) begin
                for (int k = 0; k < n_words; k++) begin
                    qi   = w[1] ? n_words - 1 - k : k;
                    data = rom_word({w[15:6], row[3:0], qi[1:0]});
                    for (int p = 0; p < 4; p++) begin
                        col = w[1] ? data[4*p +: 4] : data[12-4*p +: 4];
                        pos = int'(w[23:16]) + 4 * k + p;
                        if (col != 4'h0 && pos < LINE_W) begin
                            exp_next[pos] = {w[5:2], col};
                        end
                    end
                end
            end
        end
    endtask

    task automatic read_line();
        for (int i = 0; i < LINE_W; i++) begin
            hdump   = i;
            pxl_cen = 1'b1;
            next_cycle();
            pxl_cen = 1'b0;
            assert (pxl === exp_cur[i]) else begin
                pxl_errors++;
                $display("FAILED pxl line %0d x %0d: got %h, expected %h",
                         cur_line, i, pxl, exp_cur[i]);
            end
            next_cycle();
        end
    endtask

    // render line, then read out the one rendered before it
    task automatic run_line(input logic [7:0] line);
        int n;
        exp_cur  = exp_next;
        cur_line = next_line;
        render_line(line);
        next_line  = line;
        vrender    = line - 1'b1;
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
        n = 0;
        while (!done && n < LINE_CYCLES) begin
            next_cycle();
            n++;
        end
        assert (done === 1'b1) else begin
            other_errors++;
            $display("done did not rise within %0d cycles for line %0d", LINE_CYCLES, line);
        end
        read_line();
        lines_run++;
    endtask

    task automatic print_counts();
        $display("errors: pxl %0d, axi %0d, other %0d, assert %0d", pxl_errors, axi_errors,
                 other_errors, i_obj_engine_top.i_obj_engine_assert.fail_count);
    endtask

    // ROM with 0 to 3 cycles of delay before rom_ok
    initial begin
        int delay;
        wait (!rst);
        forever begin
            next_cycle();
            if (rom_cs) begin
                delay = 0;
                if (lfsr_bit()) begin
                    delay += 2;
                end
                if (lfsr_bit()) begin
                    delay += 1;
                end
                repeat (delay) next_cycle();
                rom_data = rom_word(rom_addr);
                rom_ok   = 1'b1;
                next_cycle();
                rom_ok   = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d lines", lines_run);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        lfsr       = 32'h5f3b;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        line_start = 1'b0;
        vrender    = '0;
        hdump      = '0;
        pxl_cen    = 1'b0;
        rom_ok     = 1'b0;
        rom_data   = '0;
        pxl_errors = 0;
        axi_errors = 0;
        other_errors = 0;
        lines_run  = 0;
        cur_line   = 0;
        next_line  = 0;
        for (int i = 0; i < LINE_W; i++) begin
            exp_next[i] = '0;       // both banks blank after reset
        end
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;
        assert (done === 1'b1) else begin
            other_errors++;
            $display("done is not high after reset");
        end

        // park every sprite on lines that are never rendered
        for (int i = 0; i < 64; i++) begin
            write_word({i[5:0], 2'b00}, 32'hf000_0000, 4'hf);
        end

        // byte strobes
        write_word(8'h14, 32'hf122_3344, 4'hf);
        write_word(8'h14, 32'h00bb_cc00, 4'b0110);
        write_word(8'h3c, 32'hf2a5_5a0f, 4'b1001);
        read_word(8'h14);
        read_word(8'h3c);
        read_word(8'h00);

        write_word(8'd3 * 4, make_obj(8'd20, 8'd40, 10'h015, 4'h5, 1'b0, 1'b0), 4'hf);
        write_word(8'd10 * 4, make_obj(8'd40, 8'd100, 10'h123, 4'h9, 1'b1, 1'b1), 4'hf);
        write_word(8'd12 * 4, make_obj(8'd40, 8'd250, 10'h2c7, 4'h3, 1'b1, 1'b1), 4'hf);
        write_word(8'd20 * 4, make_obj(8'd60, 8'd80, 10'h0aa, 4'h2, 1'b0, 1'b0), 4'hf);
        write_word(8'd21 * 4, make_obj(8'd62, 8'd84, 10'h2f1, 4'h7, 1'b0, 1'b1), 4'hf);

        run_line(8'd20);            // small sprite, first row
        run_line(8'd23);
        run_line(8'd27);
        run_line(8'd28);            // just below it
        run_line(8'd40);            // mirrored big sprites, one clipped
        run_line(8'd47);
        run_line(8'd55);
        run_line(8'd56);
        run_line(8'd62);            // 21 over 20
        run_line(8'd67);
        run_line(8'd70);
        run_line(8'd100);           // nothing here
        run_line(8'd101);           // reads back line 100

        print_counts();
        if (pxl_errors + axi_errors + other_errors
            + i_obj_engine_top.i_obj_engine_assert.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/obj_engine_assert.sv ====
/*
 * Concurrent checks on the AXI4-Lite responses, the ROM handshake and
 * done. Bound into the engine top level.
 */
`timescale 1ns/100ps

module obj_engine_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready,
    input logic                    line_start,
    input logic                    done,
    input logic                    rom_cs,
    input obj_attr_pkg::rom_addr_t rom_addr,
    input logic                    rom_ok,
    input logic                    wr_en
);

    int fail_count = 0;    // failed assertions so far

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    // address held while the ROM stalls
    rom_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("rom_addr or rom_cs changed before rom_ok");
            fail_count++;
        end

    rom_cs_drop: assert property (@(posedge clk) disable iff (rst)
        rom_cs && rom_ok |=> !rom_cs)
        else begin
            $error("rom_cs still high after rom_ok");
            fail_count++;
        end

    done_falls: assert property (@(posedge clk) disable iff (rst)
        line_start |=> !done)
        else begin
            $error("done did not fall after line_start");
            fail_count++;
        end

    done_idle: assert property (@(posedge clk) disable iff (rst)
        done |-> !rom_cs && !wr_en)
        else begin
            $error("ROM or buffer activity while done");
            fail_count++;
        end

    done_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> done)
        else begin
            $error("done low after reset");
            fail_count++;
        end

endmodule

bind obj_engine_top obj_engine_assert i_obj_engine_assert (
    .clk        (clk),
    .rst        (rst),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .line_start (line_start),
    .done       (done),
    .rom_cs     (rom_cs),
    .rom_addr   (rom_addr),
    .rom_ok     (rom_ok),
    .wr_en      (wr_en)
);

// ==== src/obj_engine_top.sv ====
/*
 * Sprite line engine top level. The CPU loads the attribute table over
 * AXI4-Lite, the scanner draws each next line from the graphics ROM and
 * the line buffer streams the current line out on pxl.
 */
`timescale 1ns/100ps

module obj_engine_top #(
    parameter int OBJ_COUNT = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    // AXI4-Lite slave
    input  logic [7:0]              awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [7:0]              araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // video timing and pixel out
    input  logic                    line_start,
    input  obj_video_pkg::vpos_t    vrender,
    input  obj_video_pkg::hpos_t    hdump,
    input  logic                    pxl_cen,
    output obj_video_pkg::pixel_t   pxl,
    output logic                    done,
    // graphics ROM
    output logic                    rom_cs,
    output obj_attr_pkg::rom_addr_t rom_addr,
    input  logic                    rom_ok,
    input  obj_attr_pkg::rom_data_t rom_data
);
    import obj_video_pkg::*;
    import obj_attr_pkg::*;

    obj_idx_t  scan_idx;
    obj_word_t scan_word;
    hpos_t     wr_addr;
    pixel_t    wr_data;
    logic      wr_en;

    obj_attr_ram #(
        .OBJ_COUNT (OBJ_COUNT)
    ) i_obj_attr_ram (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .scan_idx  (scan_idx),
        .scan_word (scan_word)
    );

    obj_scan #(
        .OBJ_COUNT (OBJ_COUNT)
    ) i_obj_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .scan_word  (scan_word),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .done       (done),
        .scan_idx   (scan_idx),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en)
    );

    obj_line_buffer i_obj_line_buffer (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en),
        .hdump      (hdump),
        .pxl_cen    (pxl_cen),
        .pxl        (pxl)
    );

endmodule

// ==== src/obj_line_buffer.sv ====
/*
 * Double line buffer. The scanner writes the back bank while the front
 * bank is read at pixel rate and erased behind the read.
 * Banks swap on line_start.
 */
`timescale 1ns/100ps

module obj_line_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  line_start,
    input  obj_video_pkg::hpos_t  wr_addr,
    input  obj_video_pkg::pixel_t wr_data,
    input  logic                  wr_en,
    input  obj_video_pkg::hpos_t  hdump,
    input  logic                  pxl_cen,
    output obj_video_pkg::pixel_t pxl
);
    import obj_video_pkg::*;

    localparam int AW = $clog2(LINE_W);

    pixel_t mem [2][LINE_W];
    logic   rd_bank;
    logic   wr_ok;
    logic   rd_ok;

    // transparent and off-screen pixels leave the bank untouched
    assign wr_ok = wr_en && (wr_data[COLOR_W-1:0] != '0) && !wr_addr[AW];
    assign rd_ok = pxl_cen && !hdump[AW];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank <= 1'b0;
        end else if (line_start) begin
            rd_bank <= ~rd_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl <= '0;
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < LINE_W; i++) begin
                    mem[b][i] <= '0; // both banks start blank
                end
            end
        end else begin
            if (wr_ok) begin
                mem[!rd_bank][wr_addr[AW-1:0]] <= wr_data;
            end
            if (pxl_cen) begin
                pxl <= rd_ok ? mem[rd_bank][hdump[AW-1:0]] : '0;
            end
            if (rd_ok) begin
                mem[rd_bank][hdump[AW-1:0]] <= '0; // erase behind the read
            end
        end
    end

endmodule

// ==== src/obj_scan.sv ====
/*
 * Per-line sprite scanner. On line_start it walks the attribute table in
 * index order, fetches the ROM words of each sprite covering the next
 * line and writes their pixels into the back bank of the line buffer.
 * done rises when the last sprite has been handled.
 */
`timescale 1ns/100ps

module obj_scan #(
    parameter int OBJ_COUNT = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_start,
    input  obj_video_pkg::vpos_t    vrender,
    input  obj_attr_pkg::obj_word_t scan_word,
    input  logic                    rom_ok,
    input  obj_attr_pkg::rom_data_t rom_data,
    output logic                    done,
    output obj_attr_pkg::obj_idx_t  scan_idx,
    output logic                    rom_cs,
    output obj_attr_pkg::rom_addr_t rom_addr,
    output obj_video_pkg::hpos_t    wr_addr,
    output obj_video_pkg::pixel_t   wr_data,
    output logic                    wr_en
);
    import obj_video_pkg::*;
    import obj_attr_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CHECK,
        ST_FETCH,
        ST_WAIT,
        ST_DRAW,
        ST_NEXT
    } state_t;

    state_t           state;
    obj_idx_t         idx;
    vpos_t            line;       // line being rendered
    hpos_t            obj_x;
    code_t            obj_code;
    pal_t             obj_pal;
    logic             obj_hflip;
    logic             obj_big;
    logic [ROW_W-1:0] obj_row;
    logic [QTR_W-1:0] word_cnt;   // screen order of the ROM word
    logic [1:0]       pxl_cnt;
    rom_data_t        pxl_data;
    hpos_t            xpos;

    vpos_t            row_diff;
    logic             covers;
    logic [QTR_W-1:0] last_word;
    logic [QTR_W-1:0] quarter;

    // coverage test on the word returned for idx
    assign row_diff  = line - vpos_t'(scan_word[Y_LSB +: Y_W]);
    assign covers    = scan_word[BIG_BIT] ? (row_diff < 8'd16) : (row_diff < 8'd8);

    assign last_word = obj_big ? 2'd3 : 2'd1;
    assign quarter   = obj_hflip ? last_word - word_cnt : word_cnt; // mirrored order

    assign scan_idx  = idx;
    assign rom_addr  = {obj_code, obj_row, quarter};

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done   <= 1'b1;
            rom_cs <= 1'b0;
            wr_en  <= 1'b0;
            idx    <= '0;
        end else if (line_start) begin
            state  <= ST_READ;
            done   <= 1'b0;
            rom_cs <= 1'b0;
            wr_en  <= 1'b0;
            idx    <= '0;
            line   <= vrender + 1'b1; // render one line ahead
        end else begin
            wr_en <= 1'b0;
            case (state)
                ST_READ: begin
                    state <= ST_CHECK; // scan_word valid next cycle
                end
                ST_CHECK: begin
                    obj_x     <= hpos_t'(scan_word[X_LSB +: X_W]);
                    obj_code  <= scan_word[CODE_LSB +: CODE_W];
                    obj_pal   <= scan_word[PAL_LSB +: PAL_W];
                    obj_hflip <= scan_word[HFLIP_BIT];
                    obj_big   <= scan_word[BIG_BIT];
                    obj_row   <= row_diff[ROW_W-1:0];
                    word_cnt  <= '0;
                    state     <= covers ? ST_FETCH : ST_NEXT;
                end
                ST_FETCH: begin
                    rom_cs <= 1'b1;
                    state  <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (rom_ok) begin
                        rom_cs   <= 1'b0;
                        pxl_data <= rom_data;
                        pxl_cnt  <= '0;
                        xpos     <= obj_x + hpos_t'({word_cnt, 2'b00});
                        state    <= ST_DRAW;
                    end
                end
                ST_DRAW: begin
                    // four pixels, one per cycle
                    wr_en    <= 1'b1;
                    wr_addr  <= xpos;
                    wr_data  <= {obj_pal, obj_hflip ? pxl_data[3:0] : pxl_data[15:12]};
                    pxl_data <= obj_hflip ? pxl_data >> 4 : pxl_data << 4;
                    xpos     <= xpos + 1'b1;
                    pxl_cnt  <= pxl_cnt + 1'b1;
                    if (pxl_cnt == 2'd3) begin
                        if (word_cnt == last_word) begin
                            state <= ST_NEXT;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= ST_FETCH;
                        end
                    end
                end
                ST_NEXT: begin
                    if (idx == obj_idx_t'(OBJ_COUNT - 1)) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= ST_READ;
                    end
                end
                default: begin
                    state <= ST_IDLE; // wait for line_start
                end
            endcase
        end
    end

endmodule

// ==== src/obj_attr_ram.sv ====
/*
 * Sprite attribute table behind an AXI4-Lite slave. The CPU writes and
 * reads words with byte strobes; a second read port with one cycle of
 * latency feeds the line scanner.
 */
`timescale 1ns/100ps

module obj_attr_ram #(
    parameter  int OBJ_COUNT = 64,
    localparam int AW        = obj_attr_pkg::OBJ_IDX_W + 2
) (
    input  logic                    clk,
    input  logic                    rst,
    // write address and data
    input  logic [AW-1:0]           awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    // write response
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // read address and data
    input  logic [AW-1:0]           araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // scanner port
    input  obj_attr_pkg::obj_idx_t  scan_idx,
    output obj_attr_pkg::obj_word_t scan_word
);
    import obj_attr_pkg::*;

    localparam int         IDX_W     = $clog2(OBJ_COUNT);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    obj_word_t        mem [OBJ_COUNT];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_fire;
    logic             rd_fire;

    // one outstanding response per direction
    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign arready = !rvalid;

    assign wr_fire = awvalid && wvalid && !bvalid; // address and data together
    assign rd_fire = arvalid && !rvalid;

    assign wr_idx  = awaddr[2 +: IDX_W]; // byte to word, wraps at OBJ_COUNT
    assign rd_idx  = araddr[2 +: IDX_W];

    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8]; // byte merge
                end
            end
        end
        if (rd_fire) begin
            rdata <= mem[rd_idx];
        end
        scan_word <= mem[scan_idx[IDX_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0; // held until taken
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/obj_attr_pkg.sv ====
/*
 * Sprite attribute word layout and the ROM port types.
 * Word from the top bit down: y, x, code, palette, hflip, big.
 */
package obj_attr_pkg;

    localparam int OBJ_IDX_W = 6;    // up to 64 sprites
    localparam int Y_W       = 8;
    localparam int X_W       = 8;
    localparam int CODE_W    = 10;
    localparam int PAL_W     = 4;
    localparam int ROW_W     = 4;    // row within a 16 pixel sprite
    localparam int QTR_W     = 2;    // four pixel quarter of a row

    // field positions inside the attribute word
    localparam int Y_LSB     = 24;
    localparam int X_LSB     = 16;
    localparam int CODE_LSB  = 6;
    localparam int PAL_LSB   = 2;
    localparam int HFLIP_BIT = 1;
    localparam int BIG_BIT   = 0;    // set for 16x16

    typedef logic [31:0]          obj_word_t;
    typedef logic [OBJ_IDX_W-1:0] obj_idx_t;
    typedef logic [CODE_W-1:0]    code_t;
    typedef logic [PAL_W-1:0]     pal_t;

    // code, then row, then quarter
    typedef logic [CODE_W+ROW_W+QTR_W-1:0] rom_addr_t;

    // four pixels, leftmost in the top nibble
    typedef logic [15:0] rom_data_t;

endpackage

// ==== src/obj_video_pkg.sv ====
/*
 * Line and pixel geometry shared by the sprite scanner, the line buffer
 * and the engine top level. Import it inside a module body and use
 * scoped names in port lists.
 */
package obj_video_pkg;

    localparam int HPOS_W  = 9;    // one bit past the visible line
    localparam int VPOS_W  = 8;
    localparam int PIXEL_W = 8;    // palette on top, colour below
    localparam int COLOR_W = 4;

    // visible pixels per line, also the depth of one buffer bank
    localparam int LINE_W  = 256;

    // horizontal pixel position, values of LINE_W and up are off screen
    typedef logic [HPOS_W-1:0]  hpos_t;

    // line number
    typedef logic [VPOS_W-1:0]  vpos_t;

    // palette and colour of one pixel, colour 0 is transparent
    typedef logic [PIXEL_W-1:0] pixel_t;

endpackage
